//--- src/icache_pkg.sv
// Shared geometry and types for the four-way instruction cache.
// Every cache module imports this package, and the widths of all
// internal buses follow from the constants below.

`default_nettype none

package icache_pkg;

   ////////////////////////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////////////////////////

   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;
   // log2 of line bytes, sets and ways
   localparam int P_LINE = 4;
   localparam int P_SETS = 4;
   localparam int P_WAYS = 2;
   localparam int PAGE_W = 12;
   localparam int BEATS  = 4;
   localparam int TAG_W  = ADDR_W - P_SETS - P_LINE;

   localparam int NWAYS = 1 << P_WAYS;
   localparam int NSETS = 1 << P_SETS;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////

   typedef logic [P_WAYS-1:0]        way_t;
   typedef logic [P_SETS-1:0]        set_t;
   typedef logic [ADDR_W-PAGE_W-1:0] ppn_t;
   typedef logic [PAGE_W-1:0]        page_off_t;

   // Physical address split
   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      set_t              set;
      logic [P_LINE-3:0] word;
      logic [1:0]        byte_off;
   } paddr_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   // 3 is most recently used, 0 is the replacement candidate
   typedef logic [P_WAYS-1:0] lru_rank_t;

   // Tag and rank write-back for one set
   typedef struct packed {
      logic [NWAYS-1:0]       tag_we;
      logic [NWAYS-1:0]       lru_we;
      tag_entry_t [NWAYS-1:0] entry;
      lru_rank_t [NWAYS-1:0]  rank;
      set_t                   set;
   } tag_wr_t;

   typedef struct packed {
      logic   hit;
      way_t   hit_way;
      way_t   victim_way;
      paddr_t paddr;
   } lookup_t;

endpackage

`default_nettype wire

//--- src/icache_tag_ram.sv
// Tag and LRU-rank storage for all ways of the cache.
// One registered read port gives the whole set to the lookup stage.
// A write to the set being read at the same edge is forwarded, so
// back-to-back accesses to one set see the latest entries and ranks.

`timescale 1ns/1ps
`default_nettype none

module icache_tag_ram
   import icache_pkg::*;
(
   input  wire                    clk,
   input  wire                    ibus_rst_n,
   input  wire                    rd_en,
   input  set_t                   rd_set,
   input  tag_wr_t                wr,
   output tag_entry_t [NWAYS-1:0] entries,
   output lru_rank_t [NWAYS-1:0]  ranks
);

   tag_entry_t tag_mem  [NWAYS][NSETS];
   lru_rank_t  rank_mem [NWAYS][NSETS];

   // Per-way tag and rank arrays
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NWAYS; w++)
      begin
         if (wr.tag_we[w])
            tag_mem[w][wr.set] <= wr.entry[w];
         if (wr.lru_we[w])
            rank_mem[w][wr.set] <= wr.rank[w];
      end
   end

   // Registered read with write forwarding
   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
      begin
         entries <= '0;
         ranks   <= '0;
      end
      else if (rd_en)
      begin
         for (int w = 0; w < NWAYS; w++)
         begin
            entries[w] <= (wr.tag_we[w] && wr.set == rd_set) ? wr.entry[w]
                                                             : tag_mem[w][rd_set];
            ranks[w]   <= (wr.lru_we[w] && wr.set == rd_set) ? wr.rank[w]
                                                             : rank_mem[w][rd_set];
         end
      end
   end

endmodule

`default_nettype wire

//--- src/icache_lookup.sv
// Second-stage lookup. Joins the physical page number with the held
// page offset, compares against every way and picks hit and victim.
// Also builds the tag and rank write-back for the current set:
// boot clearing, LRU promotion on a hit and tag allocation on a miss.

`timescale 1ns/1ps
`default_nettype none

module icache_lookup
   import icache_pkg::*;
(
   input  tag_entry_t [NWAYS-1:0] entries,
   input  lru_rank_t [NWAYS-1:0]  ranks,
   input  ppn_t                   ppn,
   input  page_off_t              page_off_q,
   input  wire                    req_q,
   input  set_t                   set_q,
   input  wire                    idle,
   input  wire                    boot,
   input  set_t                   boot_set,
   output lookup_t                result,
   output tag_wr_t                wr
);

   paddr_t           paddr;
   logic [NWAYS-1:0] match;
   way_t             hit_way;
   way_t             victim_way;
   lru_rank_t        hit_rank;

   assign paddr = paddr_t'({ppn, page_off_q});

   // Tag compare and way encoders
   always_comb
   begin
      hit_way    = '0;
      victim_way = '0;
      for (int w = 0; w < NWAYS; w++)
      begin
         match[w] = entries[w].valid && (entries[w].tag == paddr.tag);
         if (match[w])
            hit_way = way_t'(w);
         // Ranks form a permutation, so exactly one way sits at 0
         if (ranks[w] == '0)
            victim_way = way_t'(w);
      end
   end

   assign hit_rank = ranks[hit_way];

   assign result.hit        = |match;
   assign result.hit_way    = hit_way;
   assign result.victim_way = victim_way;
   assign result.paddr      = paddr;

   ////////////////////////////////////////////////////////////
   // Tag and LRU write-back
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      wr     = '0;
      wr.set = boot ? boot_set : set_q;
      if (boot)
      begin
         // Invalidate and start each rank at its way index
         for (int w = 0; w < NWAYS; w++)
         begin
            wr.tag_we[w] = 1'b1;
            wr.lru_we[w] = 1'b1;
            wr.rank[w]   = lru_rank_t'(w);
         end
      end
      else if (idle && req_q && result.hit)
      begin
         for (int w = 0; w < NWAYS; w++)
         begin
            wr.lru_we[w] = 1'b1;
            if (match[w])
               wr.rank[w] = '1;
            else if (ranks[w] > hit_rank)
               wr.rank[w] = ranks[w] - 1'b1;
            else
               wr.rank[w] = ranks[w];
         end
      end
      else if (idle && req_q)
      begin
         // Miss allocates the victim and the re-read hit promotes it
         wr.tag_we[victim_way]      = 1'b1;
         wr.entry[victim_way].valid = 1'b1;
         wr.entry[victim_way].tag   = paddr.tag;
      end
   end

endmodule

`default_nettype wire

//--- src/icache_refill_fsm.sv
// Cache control FSM. Sweeps all sets after reset, detects misses,
// issues the line address on the instruction bus and counts the
// returning beats. After the last beat the held set is read again
// so the stalled request completes as a hit.

`timescale 1ns/1ps
`default_nettype none

module icache_refill_fsm
   import icache_pkg::*;
(
   input  wire     clk,
   input  wire     ibus_rst_n,
   input  wire     req_q,
   input  lookup_t result,
   input  wire     ibus_aready,
   input  wire     ibus_bvalid,
   output logic    boot,
   output set_t    boot_set,
   output logic    idle,
   output logic    reread,
   output logic    stall,
   output logic    dout_vld,
   output logic    ibus_avalid,
   output paddr_t  ibus_aaddr,
   output logic    beat_we,
   output logic [1:0] beat,
   output way_t    fill_way,
   output set_t    fill_set
);

   typedef enum logic [2:0] {S_BOOT, S_IDLE, S_ADDR, S_DATA, S_DONE} state_t;

   state_t     state_q;
   state_t     state_d;
   set_t       set_cnt;
   logic [1:0] beat_q;
   logic       miss;
   paddr_t     line_q;
   way_t       way_q;

   assign miss = req_q && !result.hit;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_BOOT:
            if (set_cnt == '0)
               state_d = S_IDLE;
         S_IDLE:
            if (miss)
               state_d = S_ADDR;
         S_ADDR:
            if (ibus_aready)
               state_d = S_DATA;
         S_DATA:
            if (ibus_bvalid && beat_q == 2'(BEATS - 1))
               state_d = S_DONE;
         S_DONE:
            state_d = S_IDLE;
         default:
            state_d = S_BOOT;
      endcase
   end

   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
      begin
         state_q <= S_BOOT;
         set_cnt <= '1;
         beat_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == S_BOOT)
            set_cnt <= set_cnt - 1'b1;
         // Wraps back to zero after the last beat of a line
         if (beat_we)
            beat_q <= beat_q + 1'b1;
      end
   end

   // Refill target captured when leaving IDLE
   always_ff @(posedge clk)
   begin
      if (state_q == S_IDLE && miss)
      begin
         way_q  <= result.victim_way;
         line_q <= '{tag: result.paddr.tag, set: result.paddr.set, word: '0, byte_off: '0};
      end
   end

   assign boot     = (state_q == S_BOOT);
   assign idle     = (state_q == S_IDLE);
   assign reread   = (state_q == S_DONE);
   assign boot_set = set_cnt;

   // Fetch side
   assign stall    = !idle || miss;
   assign dout_vld = idle && req_q && result.hit;

   // Bus side
   assign ibus_avalid = (state_q == S_ADDR);
   assign ibus_aaddr  = line_q;
   assign beat_we     = (state_q == S_DATA) && ibus_bvalid;
   assign beat        = beat_q;
   assign fill_way    = way_q;
   assign fill_set    = line_q.set;

endmodule

`default_nettype wire

//--- src/icache_data_ram.sv
// Instruction payload storage, one word per way, set and word slot.
// Refill beats write the captured victim way. Fetch reads all ways
// of a set in one cycle and the hit way selects the output word.

`timescale 1ns/1ps
`default_nettype none

module icache_data_ram
   import icache_pkg::*;
(
   input  wire               clk,
   input  wire               rd_en,
   input  set_t              rd_set,
   input  wire [1:0]         rd_word,
   input  way_t              rd_way,
   input  wire               we,
   input  way_t              wr_way,
   input  set_t              wr_set,
   input  wire [1:0]         wr_word,
   input  wire [WORD_W-1:0]  wdata,
   output logic [WORD_W-1:0] dout
);

   logic [WORD_W-1:0] mem [NWAYS][NSETS*BEATS];
   logic [WORD_W-1:0] rd_q [NWAYS];

   always_ff @(posedge clk)
   begin
      if (we)
         mem[wr_way][{wr_set, wr_word}] <= wdata;
   end

   // All ways read in parallel, way chosen after the tag compare
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         for (int w = 0; w < NWAYS; w++)
            rd_q[w] <= mem[w][{rd_set, rd_word}];
      end
   end

   assign dout = rd_q[rd_way];

endmodule

`default_nettype wire

//--- src/icache_top.sv
// Top level of the four-way instruction cache.
// Stage 1 registers the fetch request and indexes the tag and data
// RAMs with the page offset; stage 2 compares against the late TLB
// page number. Misses refill a whole line over the burst bus.

`timescale 1ns/1ps
`default_nettype none

module icache_top
   import icache_pkg::*;
(
   input  wire               clk,
   input  wire               ibus_rst_n,
   input  wire               re,
   input  page_off_t         page_off,
   input  ppn_t              tlb_ppn,
   output logic [WORD_W-1:0] dout,
   output logic              dout_vld,
   output logic              stall,
   output logic              ibus_avalid,
   input  wire               ibus_aready,
   output paddr_t            ibus_aaddr,
   output logic [3:0]        ibus_alen,
   input  wire               ibus_bvalid,
   output logic              ibus_bready,
   input  wire [WORD_W-1:0]  ibus_bdata
);

   tag_entry_t [NWAYS-1:0] entries;
   lru_rank_t [NWAYS-1:0]  ranks;
   tag_wr_t                tag_wr;
   lookup_t                result;
   logic                   req_q;
   page_off_t              page_off_q;
   logic                   boot;
   set_t                   boot_set;
   logic                   idle;
   logic                   reread;
   logic                   beat_we;
   logic [1:0]             beat;
   way_t                   fill_way;
   set_t                   fill_set;
   logic                   rd_en;
   set_t                   rd_set;
   logic [1:0]             rd_word;

   ////////////////////////////////////////////////////////////
   // Stage 1 request register, frozen while stalled
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
         req_q <= 1'b0;
      else if (!stall)
         req_q <= re;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
         page_off_q <= page_off;
   end

   // Live index when moving, held index for the post-refill re-read
   assign rd_en   = !stall || reread || boot;
   assign rd_set  = boot  ? boot_set
                  : stall ? page_off_q[P_LINE +: P_SETS]
                  :         page_off[P_LINE +: P_SETS];
   assign rd_word = stall ? page_off_q[2 +: 2] : page_off[2 +: 2];

   icache_tag_ram u_tag_ram (
      .clk        (clk),
      .ibus_rst_n (ibus_rst_n),
      .rd_en      (rd_en),
      .rd_set     (rd_set),
      .wr         (tag_wr),
      .entries    (entries),
      .ranks      (ranks)
   );

   icache_lookup u_lookup (
      .entries    (entries),
      .ranks      (ranks),
      .ppn        (tlb_ppn),
      .page_off_q (page_off_q),
      .req_q      (req_q),
      .set_q      (page_off_q[P_LINE +: P_SETS]),
      .idle       (idle),
      .boot       (boot),
      .boot_set   (boot_set),
      .result     (result),
      .wr         (tag_wr)
   );

   icache_refill_fsm u_refill_fsm (
      .clk         (clk),
      .ibus_rst_n  (ibus_rst_n),
      .req_q       (req_q),
      .result      (result),
      .ibus_aready (ibus_aready),
      .ibus_bvalid (ibus_bvalid),
      .boot        (boot),
      .boot_set    (boot_set),
      .idle        (idle),
      .reread      (reread),
      .stall       (stall),
      .dout_vld    (dout_vld),
      .ibus_avalid (ibus_avalid),
      .ibus_aaddr  (ibus_aaddr),
      .beat_we     (beat_we),
      .beat        (beat),
      .fill_way    (fill_way),
      .fill_set    (fill_set)
   );

   icache_data_ram u_data_ram (
      .clk     (clk),
      .rd_en   (rd_en),
      .rd_set  (rd_set),
      .rd_word (rd_word),
      .rd_way  (result.hit_way),
      .we      (beat_we),
      .wr_way  (fill_way),
      .wr_set  (fill_set),
      .wr_word (beat),
      .wdata   (ibus_bdata),
      .dout    (dout)
   );

   // Whole-line bursts with every beat accepted
   assign ibus_alen   = 4'((1 << P_LINE) - 1);
   assign ibus_bready = 1'b1;

endmodule

`default_nettype wire

//--- dv/icache_bus_model.sv
// Behavioral instruction-bus slave for the cache testbench.
// Accepts one line address at a time with a random aready delay and
// returns BEATS words in ascending order, with random gaps between
// beats. Counts address phases and keeps the last address and length.

`timescale 1ns/1ps
`default_nettype none

module icache_bus_model
   import icache_pkg::*;
(
   input  wire               clk,
   input  wire               ibus_rst_n,
   input  wire               avalid,
   output logic              aready,
   input  paddr_t            aaddr,
   input  wire [3:0]         alen,
   output logic              bvalid,
   input  wire               bready,
   output logic [WORD_W-1:0] bdata,
   output int                req_count,
   output paddr_t            last_addr,
   output logic [3:0]        last_len
);

   logic              busy;
   int                beats_left;
   logic [ADDR_W-1:0] word_addr;

   // Memory contents are a fixed function of the byte address
   function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
      return addr ^ 32'hA5A5_0000;
   endfunction

   always_ff @(posedge clk or negedge ibus_rst_n)
   begin
      if (!ibus_rst_n)
      begin
         aready     <= 1'b0;
         bvalid     <= 1'b0;
         bdata      <= '0;
         busy       <= 1'b0;
         beats_left <= 0;
         word_addr  <= '0;
         req_count  <= 0;
         last_addr  <= '0;
         last_len   <= '0;
      end
      else if (!busy)
      begin
         if (avalid && aready)
         begin
            aready     <= 1'b0;
            busy       <= 1'b1;
            beats_left <= BEATS;
            word_addr  <= aaddr;
            req_count  <= req_count + 1;
            last_addr  <= aaddr;
            last_len   <= alen;
         end
         else if (avalid)
            aready <= (($urandom % 3) == 0);
      end
      else if (bvalid && bready)
      begin
         beats_left <= beats_left - 1;
         word_addr  <= word_addr + 4;
         // Next beat back to back, or a gap
         if (beats_left > 1 && ($urandom % 2) == 0)
         begin
            bvalid <= 1'b1;
            bdata  <= word_at(word_addr + 4);
         end
         else
            bvalid <= 1'b0;
         if (beats_left == 1)
            busy <= 1'b0;
      end
      else if (($urandom % 4) != 0)
      begin
         bvalid <= 1'b1;
         bdata  <= word_at(word_addr);
      end
   end

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
// Directed testbench for the four-way instruction cache.
// Drives fetches through the two-stage port against a bus slave model
// and checks boot, cold miss, line hits, LRU replacement and physical
// tagging. Inputs change on the rising edge, outputs are sampled on
// the falling edge.

`timescale 1ns/1ps
`default_nettype none

module icache_tb
   import icache_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   localparam int BOOT_LIMIT = 40;

   logic              clk;
   logic              ibus_rst_n;
   logic              re;
   page_off_t         page_off;
   ppn_t              tlb_ppn;
   logic [WORD_W-1:0] dout;
   logic              dout_vld;
   logic              stall;
   logic              ibus_avalid;
   logic              ibus_aready;
   paddr_t            ibus_aaddr;
   logic [3:0]        ibus_alen;
   logic              ibus_bvalid;
   logic              ibus_bready;
   logic [WORD_W-1:0] ibus_bdata;
   int                req_count;
   paddr_t            last_addr;
   logic [3:0]        last_len;

   int   errors;
   int   timeouts;
   ppn_t cold_ppn;
   ppn_t line_ppn [5];
   // Lines of the LRU test set in order of use
   ppn_t recency [$];

   icache_top dut0 (
      .clk         (clk),
      .ibus_rst_n  (ibus_rst_n),
      .re          (re),
      .page_off    (page_off),
      .tlb_ppn     (tlb_ppn),
      .dout        (dout),
      .dout_vld    (dout_vld),
      .stall       (stall),
      .ibus_avalid (ibus_avalid),
      .ibus_aready (ibus_aready),
      .ibus_aaddr  (ibus_aaddr),
      .ibus_alen   (ibus_alen),
      .ibus_bvalid (ibus_bvalid),
      .ibus_bready (ibus_bready),
      .ibus_bdata  (ibus_bdata)
   );

   icache_bus_model bus0 (
      .clk        (clk),
      .ibus_rst_n (ibus_rst_n),
      .avalid     (ibus_avalid),
      .aready     (ibus_aready),
      .aaddr      (ibus_aaddr),
      .alen       (ibus_alen),
      .bvalid     (ibus_bvalid),
      .bready     (ibus_bready),
      .bdata      (ibus_bdata),
      .req_count  (req_count),
      .last_addr  (last_addr),
      .last_len   (last_len)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks and reference rules
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string what, input paddr_t got, input paddr_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic note_timeout(input string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      timeouts++;
   endtask

   // Bus data rule applied to the fetched physical word
   function automatic logic [WORD_W-1:0] expected_word(input ppn_t ppn, input page_off_t off);
      return {ppn, off[PAGE_W-1:2], 2'b00} ^ 32'hA5A5_0000;
   endfunction

   // True LRU over four ways that tells whether the line was present
   function automatic bit touch_line(input ppn_t p);
      bit found;
      found = 1'b0;
      for (int i = 0; i < recency.size(); i++)
      begin
         if (!found && recency[i] == p)
         begin
            recency.delete(i);
            found = 1'b1;
         end
      end
      if (!found && recency.size() == NWAYS)
         recency.delete(0);
      recency.push_back(p);
      return found;
   endfunction

   ////////////////////////////////////////////////////////////
   // Fetch one word and check data, latency and bus traffic
   ////////////////////////////////////////////////////////////

   task automatic fetch_word(input ppn_t ppn, input page_off_t off, input bit exp_hit);
      paddr_t exp_line;
      int     req_before;
      int     n;
      exp_line = paddr_t'({ppn, off[PAGE_W-1:P_LINE], 4'h0});
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (stall && n < WAIT_LIMIT);
      if (stall)
      begin
         note_timeout("stall low before a fetch");
         return;
      end
      req_before = req_count;
      @(posedge clk);
      re       <= 1'b1;
      page_off <= off;
      // Page number follows the request edge by one cycle
      @(posedge clk);
      re      <= 1'b0;
      tlb_ppn <= ppn;
      @(negedge clk);
      check_bit("dout_vld in the first cycle", dout_vld, exp_hit);
      check_bit("stall in the first cycle", stall, !exp_hit);
      if (!exp_hit)
      begin
         @(negedge clk);
         check_bit("ibus_avalid after a miss", ibus_avalid, 1'b1);
      end
      n = 0;
      while (!dout_vld && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (!dout_vld)
      begin
         note_timeout("dout_vld");
         return;
      end
      check_bit("stall with dout_vld", stall, 1'b0);
      check_word("dout", dout, expected_word(ppn, off));
      check_count("new bus requests", req_count - req_before, exp_hit ? 0 : 1);
      if (!exp_hit)
      begin
         check_addr("line address", last_addr, exp_line);
         check_count("burst length", int'(last_len), 15);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic boot_sequence();
      int n;
      @(negedge clk);
      check_bit("stall after reset", stall, 1'b1);
      check_bit("dout_vld after reset", dout_vld, 1'b0);
      check_bit("ibus_avalid after reset", ibus_avalid, 1'b0);
      check_bit("ibus_bready after reset", ibus_bready, 1'b1);
      n = 0;
      while (stall && n < BOOT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (stall)
         note_timeout("the boot sweep to end");
   endtask

   task automatic cold_miss();
      cold_ppn = ppn_t'($urandom);
      fetch_word(cold_ppn, 12'h128, 1'b0);
      check_count("requests after the cold miss", req_count, 1);
   endtask

   task automatic line_hits();
      fetch_word(cold_ppn, 12'h120, 1'b1);
      fetch_word(cold_ppn, 12'h124, 1'b1);
      fetch_word(cold_ppn, 12'h12C, 1'b1);
      check_count("requests after the line hits", req_count, 1);
   endtask

   task automatic lru_replacement();
      ppn_t base;
      int   order [11] = '{0, 1, 2, 3, 1, 3, 0, 2, 4, 1, 2};
      base = ppn_t'($urandom);
      for (int i = 0; i < 5; i++)
         line_ppn[i] = {base[ADDR_W-PAGE_W-1:3], 3'(i)};
      // Fill four ways, touch in a new order, then evict and refetch
      foreach (order[k])
         fetch_word(line_ppn[order[k]], 12'h594, touch_line(line_ppn[order[k]]));
   endtask

   task automatic physical_tagging();
      fetch_word(~cold_ppn, 12'h128, 1'b0);
      fetch_word(cold_ppn, 12'h128, 1'b1);
   endtask

   initial
   begin
      void'($urandom(32'h56c5_4231));
      errors     = 0;
      timeouts   = 0;
      ibus_rst_n = 1'b0;
      re         = 1'b0;
      page_off   = '0;
      tlb_ppn    = '0;
      repeat (10) @(posedge clk);
      ibus_rst_n <= 1'b1;
      boot_sequence();
      cold_miss();
      line_hits();
      lru_replacement();
      physical_tagging();
      $display("icache_tb done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- icache_lite.f
src/icache_pkg.sv
src/icache_tag_ram.sv
src/icache_lookup.sv
src/icache_refill_fsm.sv
src/icache_data_ram.sv
src/icache_top.sv
dv/icache_bus_model.sv
dv/icache_tb.sv

//--- run.sh
#!/bin/sh
# Compile the cache and its testbench with Verilator and run it.
# Exits non-zero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   -f icache_lite.f \
   --top-module icache_tb \
   -Mdir obj_dir -o icache_sim

./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
   echo "run.sh: testbench reported success"
else
   echo "run.sh: testbench did not report success"
   exit 1
fi
